//--- src/ppuTypesPkg.sv
package ppuTypesPkg;

   typedef logic [8:0]   dotCount;
   typedef logic [7:0]   lineNum;
   typedef logic [12:0]  vramAddr;
   typedef logic [7:0]   byteT;
   typedef logic [4:0]   tileCol;
   typedef logic [2:0]   pixelRow;
   typedef logic [1:0]   colorIdx;

   // one bit per pixel of a line, pixel 0 at bit 0.
   // plane 0 carries the low shade bit and plane 1 the high shade bit.
   typedef logic [159:0] linePlane;

   typedef enum logic [1:0] {
      hBlank   = 2'd0,
      vBlank   = 2'd1,
      oamScan  = 2'd2,
      transfer = 2'd3
   } lcdMode;

   typedef enum logic [2:0] {
      idle,
      mapWait,
      lowWait,
      highWait,
      done
   } fetchState;

   typedef struct packed {
      vramAddr addr;
      byteT    wrData;
      logic    wr;
      logic    rd;
   } vramReq;

endpackage

//--- src/ppuRegPkg.sv
package ppuRegPkg;

   localparam logic [15:0] lcdcAddr = 16'hFF40;
   localparam logic [15:0] statAddr = 16'hFF41;
   localparam logic [15:0] lyAddr   = 16'hFF44;
   localparam logic [15:0] lycAddr  = 16'hFF45;
   localparam logic [15:0] bgpAddr  = 16'hFF47;

   // the CPU sees VRAM in this window.
   localparam logic [15:0] vramBase = 16'h8000;
   localparam logic [15:0] vramTop  = 16'h9FFF;

   typedef struct packed {
      logic [15:0]       addr;
      ppuTypesPkg::byteT wrData;
      logic              cs;
      logic              wr;
      logic              rd;
   } cpuBus;

   typedef struct packed {
      logic              enable;
      ppuTypesPkg::byteT lcdc;
      ppuTypesPkg::byteT lyc;
      ppuTypesPkg::byteT bgp;
   } lcdConfig;

endpackage

//--- src/lcdTiming.sv
`timescale 1ns/1ns

module lcdTiming #(
   parameter int dotsPerLine   = 456,
   parameter int linesPerFrame = 154,
   parameter int visibleLines  = 144,
   parameter int oamDots       = 80,
   parameter int transferDots  = 172
) (
   input  logic                 clock,
   input  logic                 rstN,
   input  ppuRegPkg::lcdConfig  cfg,
   output ppuTypesPkg::dotCount dot,
   output ppuTypesPkg::lineNum  ly,
   output ppuTypesPkg::lcdMode  mode,
   output logic                 lineStart,
   output logic                 irq
);
   import ppuTypesPkg::*;

   dotCount dotNext;
   lineNum  lyNext;
   logic    running;

   // the counters move only once the enable has been registered, so the
   // first enabled cycle sits on dot 0 of line 0.
   always_comb begin
      dotNext = dot;
      lyNext  = ly;
      if (!cfg.enable) begin
         dotNext = '0;
         lyNext  = '0;
      end else if (running) begin
         if (dot == dotCount'(dotsPerLine - 1)) begin
            dotNext = '0;
            if (ly == lineNum'(linesPerFrame - 1))
               lyNext = '0;
            else
               lyNext = ly + 1'b1;
         end else begin
            dotNext = dot + 1'b1;
         end
      end
   end

   always_ff @(posedge clock or negedge rstN) begin
      if (!rstN) begin
         dot     <= '0;
         ly      <= '0;
         running <= 1'b0;
         irq     <= 1'b0;
      end else begin
         dot     <= dotNext;
         ly      <= lyNext;
         running <= cfg.enable;
         // computed from the next line so that irq lines up with vBlank.
         irq     <= cfg.enable && (lyNext >= lineNum'(visibleLines));
      end
   end

   always_comb begin
      if (!running)
         mode = hBlank;
      else if (ly >= lineNum'(visibleLines))
         mode = vBlank;
      else if (dot < dotCount'(oamDots))
         mode = oamScan;
      else if (dot < dotCount'(oamDots + transferDots))
         mode = transfer;
      else
         mode = hBlank;
   end

   assign lineStart = running && (dot == '0);

endmodule

//--- src/lcdRegisters.sv
`timescale 1ns/1ns

module lcdRegisters (
   input  logic                clock,
   input  logic                rstN,
   input  ppuRegPkg::cpuBus    cpu,
   input  ppuTypesPkg::lineNum ly,
   input  ppuTypesPkg::lcdMode mode,
   input  ppuTypesPkg::byteT   vramCpuData,
   output ppuRegPkg::lcdConfig cfg,
   output ppuTypesPkg::byteT   cpuRdData
);
   import ppuTypesPkg::*;
   import ppuRegPkg::*;

   byteT lcdc;
   byteT lyc;
   byteT bgp;
   byteT stat;
   byteT regData;
   byteT rdDataQ;
   logic wrEn;
   logic rdEn;
   logic vramHit;
   logic vramHitQ;

   assign wrEn    = cpu.cs && cpu.wr;
   assign rdEn    = cpu.cs && cpu.rd;
   assign vramHit = (cpu.addr >= vramBase) && (cpu.addr <= vramTop);

   always_ff @(posedge clock or negedge rstN) begin
      if (!rstN) begin
         lcdc     <= '0;
         lyc      <= '0;
         bgp      <= '0;
         vramHitQ <= 1'b0;
      end else begin
         if (wrEn) begin
            // LY and STAT are read only here.
            case (cpu.addr)
               lcdcAddr: lcdc <= cpu.wrData;
               lycAddr:  lyc  <= cpu.wrData;
               bgpAddr:  bgp  <= cpu.wrData;
               default:  ;
            endcase
         end
         if (rdEn)
            vramHitQ <= vramHit;
      end
   end

   // coincidence flag in bit 2, mode in bits 1 to 0.
   assign stat = {5'b0, ly == lyc, mode};

   always_comb begin
      case (cpu.addr)
         lcdcAddr: regData = lcdc;
         statAddr: regData = stat;
         lyAddr:   regData = ly;
         lycAddr:  regData = lyc;
         bgpAddr:  regData = bgp;
         default:  regData = 8'hFF;
      endcase
   end

   always_ff @(posedge clock) begin
      if (rdEn)
         rdDataQ <= regData;
   end

   // VRAM data arrives one cycle after the request, so it is picked here.
   assign cpuRdData = vramHitQ ? vramCpuData : rdDataQ;

   assign cfg = '{enable: lcdc[7], lcdc: lcdc, lyc: lyc, bgp: bgp};

endmodule

//--- src/bgFetcher.sv
`timescale 1ns/1ns

module bgFetcher #(
   parameter int tilesPerLine = 20
) (
   input  logic                clock,
   input  logic                rstN,
   input  ppuRegPkg::cpuBus    cpu,
   input  ppuTypesPkg::lcdMode mode,
   input  ppuTypesPkg::lineNum ly,
   input  ppuTypesPkg::byteT   vramRdData,
   output ppuTypesPkg::vramReq vram,
   output ppuTypesPkg::byteT   vramCpuData,
   output ppuTypesPkg::byteT   pixByte,
   output logic                pixPlane,
   output ppuTypesPkg::tileCol pixCol,
   output logic                pixStrobe
);
   import ppuTypesPkg::*;
   import ppuRegPkg::*;

   fetchState state;
   logic      waitCycle;
   tileCol    col;
   byteT      tileNum;
   pixelRow   row;
   vramAddr   mapAddr;
   vramAddr   dataAddr;
   vramAddr   fetchAddr;
   logic      ownPort;
   logic      cpuVram;
   logic      cpuGrantQ;

   assign ownPort = (mode == transfer);
   assign cpuVram = cpu.cs && (cpu.addr >= vramBase) && (cpu.addr <= vramTop);
   assign row     = ly[2:0];

   // map row is ly/8, each map row holds 32 tile numbers.
   assign mapAddr   = 13'h1800 + {ly[7:3], 5'b0} + vramAddr'(col);
   assign dataAddr  = {1'b0, tileNum, row, state == highWait};
   assign fetchAddr = (state == idle || state == mapWait) ? mapAddr : dataAddr;

   // every read holds its address for two cycles and the byte is taken at
   // the end of the second one, which gives six cycles per tile.
   always_ff @(posedge clock or negedge rstN) begin
      if (!rstN) begin
         state     <= idle;
         waitCycle <= 1'b0;
         col       <= '0;
      end else if (!ownPort) begin
         state     <= idle;
         waitCycle <= 1'b0;
         col       <= '0;
      end else begin
         case (state)
            idle: begin
               // the first transfer dot already drives the map address.
               state     <= mapWait;
               waitCycle <= 1'b1;
            end
            mapWait, lowWait: begin
               waitCycle <= !waitCycle;
               if (waitCycle)
                  state <= (state == mapWait) ? lowWait : highWait;
            end
            highWait: begin
               waitCycle <= !waitCycle;
               if (waitCycle) begin
                  if (col == tileCol'(tilesPerLine - 1)) begin
                     state <= done;
                  end else begin
                     state <= mapWait;
                     col   <= col + 1'b1;
                  end
               end
            end
            default: ;
         endcase
      end
   end

   always_ff @(posedge clock) begin
      if (state == mapWait && waitCycle)
         tileNum <= vramRdData;
   end

   always_ff @(posedge clock or negedge rstN) begin
      if (!rstN)
         cpuGrantQ <= 1'b0;
      else
         cpuGrantQ <= !ownPort;
   end

   always_comb begin
      if (ownPort) begin
         vram.addr   = fetchAddr;
         vram.wrData = '0;
         vram.wr     = 1'b0;
         vram.rd     = (state != done);
      end else begin
         vram.addr   = vramAddr'(cpu.addr - vramBase);
         vram.wrData = cpu.wrData;
         vram.wr     = cpuVram && cpu.wr;
         vram.rd     = cpuVram && cpu.rd;
      end
   end

   // a CPU read issued while the renderer held the port sees 0xFF.
   assign vramCpuData = cpuGrantQ ? vramRdData : 8'hFF;

   assign pixByte   = vramRdData;
   assign pixPlane  = (state == highWait);
   assign pixCol    = col;
   assign pixStrobe = waitCycle && (state == lowWait || state == highWait);

endmodule

//--- src/lineComposer.sv
`timescale 1ns/1ns

module lineComposer #(
   parameter int visibleLines = 144
) (
   input  logic                  clock,
   input  logic                  rstN,
   input  ppuRegPkg::lcdConfig   cfg,
   input  ppuTypesPkg::lcdMode   mode,
   input  ppuTypesPkg::lineNum   ly,
   input  ppuTypesPkg::byteT     pixByte,
   input  logic                  pixPlane,
   input  ppuTypesPkg::tileCol   pixCol,
   input  logic                  pixStrobe,
   output ppuTypesPkg::linePlane lineLow,
   output ppuTypesPkg::linePlane lineHigh,
   output logic                  lineReady
);
   import ppuTypesPkg::*;

   byteT       lowByte;
   byteT       shadeLow;
   byteT       shadeHigh;
   linePlane   workLow;
   linePlane   workHigh;
   lcdMode     modeQ;
   logic       lineEnd;
   logic [7:0] pixBase;

   function automatic colorIdx mapShade(colorIdx shade, byteT palette);
      return palette[2 * shade +: 2];
   endfunction

   // the most significant byte bit is the leftmost pixel of the tile.
   always_comb begin
      for (int i = 0; i < 8; i++) begin
         {shadeHigh[i], shadeLow[i]} = mapShade({pixByte[7 - i], lowByte[7 - i]}, cfg.bgp);
      end
   end

   assign pixBase = {pixCol, 3'b000};
   assign lineEnd = (mode == hBlank) && (modeQ == transfer) &&
                    (ly < lineNum'(visibleLines));

   always_ff @(posedge clock or negedge rstN) begin
      if (!rstN) begin
         modeQ     <= hBlank;
         lineReady <= 1'b0;
      end else begin
         modeQ     <= mode;
         lineReady <= lineEnd;
      end
   end

   always_ff @(posedge clock) begin
      if (pixStrobe && !pixPlane)
         lowByte <= pixByte;
      if (pixStrobe && pixPlane) begin
         workLow[pixBase +: 8]  <= shadeLow;
         workHigh[pixBase +: 8] <= shadeHigh;
      end
      // outputs hold the finished line until the next hBlank.
      if (lineEnd) begin
         lineLow  <= workLow;
         lineHigh <= workHigh;
      end
   end

endmodule

//--- src/ppuTop.sv
`timescale 1ns/1ns

module ppuTop #(
   parameter int dotsPerLine   = 456,
   parameter int linesPerFrame = 154,
   parameter int visibleLines  = 144,
   parameter int oamDots       = 80,
   parameter int transferDots  = 172,
   parameter int tilesPerLine  = 20
) (
   input  logic                  clock,
   input  logic                  rstN,
   input  ppuRegPkg::cpuBus      cpu,
   output ppuTypesPkg::byteT     cpuRdData,
   output ppuTypesPkg::vramReq   vram,
   input  ppuTypesPkg::byteT     vramRdData,
   output logic                  irq,
   output ppuTypesPkg::lineNum   ly,
   output ppuTypesPkg::linePlane lineLow,
   output ppuTypesPkg::linePlane lineHigh,
   output logic                  lineReady
);
   import ppuTypesPkg::*;
   import ppuRegPkg::*;

   lcdConfig cfg;
   lcdMode   mode;
   byteT     vramCpuData;
   byteT     pixByte;
   logic     pixPlane;
   tileCol   pixCol;
   logic     pixStrobe;

   lcdTiming #(
      .dotsPerLine  (dotsPerLine),
      .linesPerFrame(linesPerFrame),
      .visibleLines (visibleLines),
      .oamDots      (oamDots),
      .transferDots (transferDots)
   ) lcdTiming_inst (
      .clock    (clock),
      .rstN     (rstN),
      .cfg      (cfg),
      .dot      (),
      .ly       (ly),
      .mode     (mode),
      .lineStart(),
      .irq      (irq)
   );

   lcdRegisters lcdRegisters_inst (
      .clock      (clock),
      .rstN       (rstN),
      .cpu        (cpu),
      .ly         (ly),
      .mode       (mode),
      .vramCpuData(vramCpuData),
      .cfg        (cfg),
      .cpuRdData  (cpuRdData)
   );

   bgFetcher #(
      .tilesPerLine(tilesPerLine)
   ) bgFetcher_inst (
      .clock      (clock),
      .rstN       (rstN),
      .cpu        (cpu),
      .mode       (mode),
      .ly         (ly),
      .vramRdData (vramRdData),
      .vram       (vram),
      .vramCpuData(vramCpuData),
      .pixByte    (pixByte),
      .pixPlane   (pixPlane),
      .pixCol     (pixCol),
      .pixStrobe  (pixStrobe)
   );

   lineComposer #(
      .visibleLines(visibleLines)
   ) lineComposer_inst (
      .clock    (clock),
      .rstN     (rstN),
      .cfg      (cfg),
      .mode     (mode),
      .ly       (ly),
      .pixByte  (pixByte),
      .pixPlane (pixPlane),
      .pixCol   (pixCol),
      .pixStrobe(pixStrobe),
      .lineLow  (lineLow),
      .lineHigh (lineHigh),
      .lineReady(lineReady)
   );

endmodule

//--- tests/ppuTiming_assertions.sv
`timescale 1ns/1ns

module ppuTimingAssertions #(
   parameter int visibleLines = 144
) (
   input logic                clock,
   input logic                rstN,
   input ppuTypesPkg::lineNum ly,
   input ppuTypesPkg::lcdMode mode,
   input logic                lineStart,
   input logic                irq
);
   import ppuTypesPkg::*;

   int failCount = 0;

   // the interrupt level follows the vBlank mode on every cycle.
   irqMatchesVBlank: assert property (@(posedge clock) disable iff (!rstN)
      irq == (mode == vBlank))
      else begin
         $error("irq does not match the vBlank mode");
         failCount++;
      end

   lineStartOneCycle: assert property (@(posedge clock) disable iff (!rstN)
      lineStart |=> !lineStart)
      else begin
         $error("lineStart is wider than one cycle");
         failCount++;
      end

   noTransferInVBlank: assert property (@(posedge clock) disable iff (!rstN)
      (ly >= lineNum'(visibleLines)) |-> (mode != transfer))
      else begin
         $error("transfer mode seen on a vBlank line");
         failCount++;
      end

endmodule

bind lcdTiming ppuTimingAssertions #(
   .visibleLines(visibleLines)
) ppuTimingAssertions_inst (
   .clock    (clock),
   .rstN     (rstN),
   .ly       (ly),
   .mode     (mode),
   .lineStart(lineStart),
   .irq      (irq)
);

//--- tests/ppuTbLib.svh
`ifndef PPU_TB_LIB_SVH
`define PPU_TB_LIB_SVH

int          checkCount      = 0;
int          errorCount      = 0;
int          testStartErrors = 0;
logic [31:0] rngState        = 32'he681;

function automatic logic [31:0] xorshift(input logic [31:0] x);
   x = x ^ (x << 13);
   x = x ^ (x >> 17);
   x = x ^ (x << 5);
   return x;
endfunction

function automatic byteT randomByte();
   rngState = xorshift(rngState);
   return rngState[7:0];
endfunction

// builds one background line from the map at 0x1800, the tile data at 0x0000
// and the BGP fields, with the leftmost pixel taken from bit 7 of each byte.
function automatic void refLine(input byteT mem[8192], input lineNum line,
                                input byteT bgp, output linePlane low,
                                output linePlane high);
   int         mapAddr;
   int         dataAddr;
   int         bitPos;
   byteT       tile;
   logic [1:0] shade;
   logic [1:0] color;
   for (int x = 0; x < 160; x++) begin
      mapAddr  = 'h1800 + 32 * (line / 8) + x / 8;
      tile     = mem[mapAddr];
      dataAddr = 16 * tile + 2 * (line % 8);
      bitPos   = 7 - x % 8;
      shade    = {mem[dataAddr + 1][bitPos], mem[dataAddr][bitPos]};
      color    = bgp[2 * shade +: 2];
      low[x]   = color[0];
      high[x]  = color[1];
   end
endfunction

task automatic checkByte(input string name, input byteT got, input byteT exp);
   checkCount++;
   if (got !== exp) begin
      errorCount++;
      $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
   end
endtask

task automatic checkPlane(input string name, input linePlane got, input linePlane exp);
   checkCount++;
   if (got !== exp) begin
      errorCount++;
      $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
   end
endtask

task automatic checkBit(input string name, input logic got, input logic exp);
   checkCount++;
   if (got !== exp) begin
      errorCount++;
      $display("CHECK FAILED at %0t ns: %s is %b, expected %b", $time, name, got, exp);
   end
endtask

task automatic reportTest(input string name);
   int failed;
   failed = errorCount - testStartErrors;
   $display("test %-10s %s (%0d errors)", name, (failed == 0) ? "ok" : "failed", failed);
   testStartErrors = errorCount;
endtask

`endif

//--- tests/ppuTb.sv
`timescale 1ns/1ns

module ppuTb;
   import ppuTypesPkg::*;
   import ppuRegPkg::*;

   localparam int  dotsPerLine   = 456;
   localparam int  linesPerFrame = 154;
   localparam int  visibleLines  = 144;
   localparam int  oamDots       = 80;
   localparam int  transferDots  = 172;
   localparam int  tilesPerLine  = 20;
   localparam int  linesToRender = 20;
   localparam time frameNs       = dotsPerLine * linesPerFrame * 20;
   localparam time watchdogNs    = 3 * frameNs + frameNs / 4;

   logic     clock;
   logic     rstN;
   cpuBus    cpu;
   byteT     cpuRdData;
   vramReq   vram;
   byteT     vramRdData;
   logic     irq;
   lineNum   ly;
   linePlane lineLow;
   linePlane lineHigh;
   logic     lineReady;

   byteT   vramMem [8192];
   longint cycleCount   = 0;
   longint syncCycle    = 0;
   byteT   bgpVal;
   byteT   lycVal;
   logic   renderOn     = 1'b0;
   int     linesChecked = 0;

   `include "ppuTbLib.svh"

   ppuTop #(
      .dotsPerLine  (dotsPerLine),
      .linesPerFrame(linesPerFrame),
      .visibleLines (visibleLines),
      .oamDots      (oamDots),
      .transferDots (transferDots),
      .tilesPerLine (tilesPerLine)
   ) ppuTop_inst (
      .clock     (clock),
      .rstN      (rstN),
      .cpu       (cpu),
      .cpuRdData (cpuRdData),
      .vram      (vram),
      .vramRdData(vramRdData),
      .irq       (irq),
      .ly        (ly),
      .lineLow   (lineLow),
      .lineHigh  (lineHigh),
      .lineReady (lineReady)
   );

   initial begin
      clock = 1'b0;
      forever #10 clock = ~clock;
   end

   always @(posedge clock)
      cycleCount <= cycleCount + 1;

   // behavioral VRAM that returns read data one cycle after the address.
   always @(posedge clock) begin
      if (vram.wr)
         vramMem[vram.addr] <= vram.wrData;
      if (vram.rd)
         vramRdData <= vramMem[vram.addr];
   end

   // dot 0 of line 1 is the cycle on which ly is first seen at 1.
   function automatic int expDot();
      return int'((cycleCount - syncCycle) % dotsPerLine);
   endfunction

   function automatic int expLine();
      return int'((1 + (cycleCount - syncCycle) / dotsPerLine) % linesPerFrame);
   endfunction

   function automatic lcdMode expMode(input int line, input int d);
      if (line >= visibleLines)
         return vBlank;
      if (d < oamDots)
         return oamScan;
      if (d < oamDots + transferDots)
         return transfer;
      return hBlank;
   endfunction

   task automatic writeBus(input logic [15:0] addr, input byteT data);
      cpu = '{addr: addr, wrData: data, cs: 1'b1, wr: 1'b1, rd: 1'b0};
      @(negedge clock);
      cpu = '0;
   endtask

   task automatic readBus(input logic [15:0] addr, output byteT data);
      cpu = '{addr: addr, wrData: 8'h00, cs: 1'b1, wr: 1'b0, rd: 1'b1};
      @(negedge clock);
      data = cpuRdData;
      cpu  = '0;
   endtask

   task automatic waitForDot(input int line, input int d);
      while (expLine() != line || expDot() != d)
         @(negedge clock);
   endtask

   always @(negedge clock) begin
      linePlane expLow;
      linePlane expHigh;
      if (renderOn && lineReady && linesChecked < linesToRender) begin
         refLine(vramMem, lineNum'(expLine()), bgpVal, expLow, expHigh);
         checkPlane("lineLow", lineLow, expLow);
         checkPlane("lineHigh", lineHigh, expHigh);
         linesChecked++;
      end
   end

   initial begin
      #(watchdogNs);
      $display("timeout: the tests did not finish within %0t ns", watchdogNs);
      $display("CHECKS FAILED");
      $finish;
   end

   initial begin
      byteT        got;
      byteT        value;
      byteT        saved;
      byteT        expStat;
      logic [12:0] addr;
      int          line;
      int          d;
      int          pulses;
      logic        lineSeen;
      int          assertFails;

      cpu        = '0;
      vramRdData = 8'h00;
      rstN       = 1'b0;
      for (int i = 0; i < 8192; i++)
         vramMem[i] = randomByte();
      repeat (16) @(posedge clock);
      @(negedge clock);
      rstN = 1'b1;
      @(negedge clock);

      checkByte("ly", ly, 8'h00);
      checkBit("irq", irq, 1'b0);
      checkBit("lineReady", lineReady, 1'b0);
      checkBit("vram.wr", vram.wr, 1'b0);
      readBus(lcdcAddr, got);
      checkByte("LCDC", got, 8'h00);
      readBus(lycAddr, got);
      checkByte("LYC", got, 8'h00);
      readBus(bgpAddr, got);
      checkByte("BGP", got, 8'h00);
      reportTest("reset");

      repeat (4) begin
         value = randomByte();
         writeBus(lcdcAddr, value);
         readBus(lcdcAddr, got);
         checkByte("LCDC", got, value);
         value = randomByte();
         writeBus(lycAddr, value);
         readBus(lycAddr, got);
         checkByte("LYC", got, value);
         bgpVal = randomByte();
         writeBus(bgpAddr, bgpVal);
         readBus(bgpAddr, got);
         checkByte("BGP", got, bgpVal);
      end
      lycVal = 8'd2 + (randomByte() % 8);
      writeBus(lycAddr, lycVal);
      writeBus(lcdcAddr, 8'h00);
      writeBus(lyAddr, 8'h5A);
      readBus(lyAddr, got);
      checkByte("LY", got, 8'h00);
      writeBus(lcdcAddr, 8'h91);
      while (ly != 8'd1)
         @(negedge clock);
      syncCycle = cycleCount;
      repeat (40) begin
         repeat (randomByte()) @(negedge clock);
         line    = expLine();
         d       = expDot();
         expStat = {5'b0, line == lycVal, expMode(line, d)};
         readBus(statAddr, got);
         checkByte("STAT", got, expStat);
      end
      reportTest("registers");

      // this covers one whole frame and counts pulses only on complete lines.
      pulses   = 0;
      lineSeen = 1'b0;
      repeat (dotsPerLine * linesPerFrame) begin
         @(negedge clock);
         line = expLine();
         d    = expDot();
         if (d == 0) begin
            pulses   = 0;
            lineSeen = 1'b1;
         end
         checkByte("ly", ly, byteT'(line));
         checkBit("irq", irq, line >= visibleLines);
         if (lineReady)
            pulses++;
         if (line >= visibleLines)
            checkBit("lineReady", lineReady, 1'b0);
         if (lineSeen && d == dotsPerLine - 1)
            checkByte("lineReady pulses", byteT'(pulses),
                      byteT'((line < visibleLines) ? 1 : 0));
      end
      reportTest("timing");

      while (lineReady)
         @(negedge clock);
      renderOn = 1'b1;
      wait (linesChecked == linesToRender);
      renderOn = 1'b0;
      reportTest("render");

      line  = expLine() + 1;
      value = randomByte();
      addr  = {value[4:0], randomByte()};
      saved = vramMem[addr];
      waitForDot(line, 120);
      readBus(vramBase + addr, got);
      checkByte("VRAM read in transfer", got, 8'hFF);
      writeBus(vramBase + addr, ~saved);
      checkByte("VRAM after write in transfer", vramMem[addr], saved);
      waitForDot(line, 300);
      readBus(vramBase + addr, got);
      checkByte("VRAM read in hBlank", got, saved);
      writeBus(vramBase + addr, ~saved);
      checkByte("VRAM after write in hBlank", vramMem[addr], ~saved);
      value = randomByte();
      addr  = {value[4:0], randomByte()};
      saved = vramMem[addr];
      waitForDot(visibleLines + 3, 40);
      readBus(vramBase + addr, got);
      checkByte("VRAM read in vBlank", got, saved);
      writeBus(vramBase + addr, ~saved);
      checkByte("VRAM after write in vBlank", vramMem[addr], ~saved);
      reportTest("lockout");

      assertFails = ppuTop_inst.lcdTiming_inst.ppuTimingAssertions_inst.failCount;
      $display("checks run: %0d, value errors: %0d, assertion failures: %0d",
               checkCount, errorCount, assertFails);
      if (errorCount == 0 && assertFails == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

//--- ppu.f
+incdir+tests
src/ppuTypesPkg.sv
src/ppuRegPkg.sv
src/lcdTiming.sv
src/lcdRegisters.sv
src/bgFetcher.sv
src/lineComposer.sv
src/ppuTop.sv
tests/ppuTiming_assertions.sv
tests/ppuTb.sv

//--- Bender.yml
package:
  name: ppu

sources:
  - files:
      - src/ppuTypesPkg.sv
      - src/ppuRegPkg.sv
      - src/lcdTiming.sv
      - src/lcdRegisters.sv
      - src/bgFetcher.sv
      - src/lineComposer.sv
      - src/ppuTop.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/ppuTiming_assertions.sv
      - tests/ppuTb.sv
